/* la_commit_defines.svh */
`ifndef LA_COMMIT_DEFINES_SVH
`define LA_COMMIT_DEFINES_SVH

// datapath shape
`define ISSUE_WIDTH     2
`define PIPE_WIDTH      8
`define REG_ADDR_WIDTH  5
`define CSR_ADDR_WIDTH  14

// exception csr addresses
`define CSR_CRMD    14'h0
`define CSR_PRMD    14'h1
`define CSR_ECFG    14'h4
`define CSR_ESTAT   14'h5
`define CSR_ERA     14'h6
`define CSR_BADV    14'h7
`define CSR_EENTRY  14'hc

// estat ecode values
`define ECODE_INT   6'h0
`define ECODE_ADE   6'h8
`define ECODE_ALE   6'h9
`define ECODE_SYS   6'hb
`define ECODE_BRK   6'hc
`define ECODE_INE   6'hd
`define ECODE_IPE   6'he

`endif

/* la_commit_pkg.sv */
`default_nettype none

`include "la_commit_defines.svh"

package la_commit_pkg;

    typedef enum logic [3:0] {
        NOP, INT, ADEF, ADEM, ALE, SYS, BRK, INE, IPE
    } exc_cause_e;

    typedef enum logic [1:0] {
        NORMAL, ERTN, IDLE
    } aluop_e;

    typedef struct packed {
        logic                           reg_write_en;
        logic [`REG_ADDR_WIDTH-1:0]     reg_write_addr;
        logic [31:0]                    reg_write_data;
        logic                           csr_write_en;
        logic [`CSR_ADDR_WIDTH-1:0]     csr_write_addr;
        logic [31:0]                    csr_write_data;
    } mem_wb_t;

    // one is_exception bit per stage that can raise
    typedef struct packed {
        logic                   valid;
        logic [31:0]            pc;
        logic [31:0]            mem_addr;
        aluop_e                 aluop;
        logic                   is_privilege;
        logic [5:0]             is_exception;
        exc_cause_e [5:0]       exception_cause;
    } commit_ctrl_t;

    typedef struct packed {
        logic pause_if;
        logic pause_icache;
        logic pause_buffer;
        logic pause_decoder;
        logic pause_dispatch;
        logic pause_execute;
        logic pause_mem;
    } pause_t;

    typedef struct packed {
        logic [27:0]    rsvd;
        logic           da;
        logic           ie;
        logic [1:0]     plv;
    } crmd_fields_t;

    typedef union packed {
        logic [31:0]    raw;
        crmd_fields_t   f;
    } crmd_u;

    typedef struct packed {
        crmd_u          crmd;
        logic [31:0]    era;
        logic [31:0]    eentry;
        logic           is_interrupt;
    } csr_state_t;

    typedef struct packed {
        logic                           exception;
        logic                           ertn;
        logic [31:0]                    exception_pc;
        logic                           badv_valid;
        logic [31:0]                    badv;
        logic [5:0]                     ecode;
        logic [8:0]                     esubcode;
        logic                           csr_write_en;
        logic [`CSR_ADDR_WIDTH-1:0]     csr_write_addr;
        logic [31:0]                    csr_write_data;
    } excp_event_t;

    typedef struct packed {
        logic                           psel;
        logic                           penable;
        logic                           pwrite;
        logic [`CSR_ADDR_WIDTH-1:0]     paddr;
        logic [31:0]                    pwdata;
    } apb_req_t;

    typedef struct packed {
        logic           pready;
        logic [31:0]    prdata;
        logic           pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* excp_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_commit_defines.svh"

module excp_encoder
    import la_commit_pkg::*;
(
    input  commit_ctrl_t                commit_i [`ISSUE_WIDTH],
    input  logic                        int_i,
    input  logic [1:0]                  plv_i,
    output logic [`ISSUE_WIDTH-1:0]     excp_o,
    output exc_cause_e                  cause_o,
    output logic [5:0]                  ecode_o,
    output logic [8:0]                  esubcode_o
);
    exc_cause_e slot_cause [`ISSUE_WIDTH];

    // interrupts are only taken on a valid slot 0
    assign excp_o[0] = commit_i[0].valid && (commit_i[0].is_exception != 6'b0 || int_i);
    assign excp_o[1] = commit_i[1].valid && commit_i[1].is_exception != 6'b0;

    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            slot_cause[i] = NOP;
            // later stages overwrite earlier ones
            for (int s = 0; s < 6; s++) begin
                if (commit_i[i].is_exception[s]) begin
                    if (s == 2 && commit_i[i].is_privilege && plv_i != 2'b00) begin
                        slot_cause[i] = IPE;
                    end else begin
                        slot_cause[i] = commit_i[i].exception_cause[s];
                    end
                end
            end
            if (i == 0 && int_i) begin
                slot_cause[i] = INT;
            end
            if (!excp_o[i]) begin
                slot_cause[i] = NOP;
            end
        end
    end

    assign cause_o = excp_o[0] ? slot_cause[0] : slot_cause[1];

    always_comb begin
        esubcode_o = 9'd0;
        case (cause_o)
            ADEF:    ecode_o = `ECODE_ADE;
            ADEM: begin
                ecode_o    = `ECODE_ADE;
                esubcode_o = 9'd1;
            end
            ALE:     ecode_o = `ECODE_ALE;
            SYS:     ecode_o = `ECODE_SYS;
            BRK:     ecode_o = `ECODE_BRK;
            INE:     ecode_o = `ECODE_INE;
            IPE:     ecode_o = `ECODE_IPE;
            default: ecode_o = `ECODE_INT;
        endcase
    end
endmodule

`default_nettype wire

/* commit_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_commit_defines.svh"

module commit_ctrl
    import la_commit_pkg::*;
(
    input  pause_t                                          pause_req_i,
    input  logic                                            branch_flush_i,
    input  logic [31:0]                                     branch_target_i,
    input  mem_wb_t                                         wb_i [`ISSUE_WIDTH],
    input  commit_ctrl_t                                    commit_i [`ISSUE_WIDTH],
    input  csr_state_t                                      csr_i,
    output excp_event_t                                     excp_o,
    output logic [`PIPE_WIDTH-1:0]                          flush_o,
    output logic [`PIPE_WIDTH-1:0]                          pause_o,
    output logic [31:0]                                     new_pc_o,
    output logic [`ISSUE_WIDTH-1:0]                         rf_we_o,
    output logic [`ISSUE_WIDTH-1:0][`REG_ADDR_WIDTH-1:0]    rf_waddr_o,
    output logic [`ISSUE_WIDTH-1:0][31:0]                   rf_wdata_o
);
    logic [`ISSUE_WIDTH-1:0]    slot_excp;
    exc_cause_e                 cause;
    logic [5:0]                 ecode;
    logic [8:0]                 esubcode;
    logic                       any_excp;
    logic                       is_ertn;
    logic                       redirect;
    logic                       pause_idle;
    logic                       xslot;

    excp_encoder u_excp (
        .commit_i   (commit_i),
        .int_i      (csr_i.is_interrupt),
        .plv_i      (csr_i.crmd.f.plv),
        .excp_o     (slot_excp),
        .cause_o    (cause),
        .ecode_o    (ecode),
        .esubcode_o (esubcode)
    );

    assign any_excp = |slot_excp;
    assign is_ertn  = commit_i[0].valid && commit_i[0].is_exception == 6'b0 &&
                      commit_i[0].aluop == ERTN && !slot_excp[0];
    assign redirect = any_excp || is_ertn;
    // slot that supplies pc and badv
    assign xslot    = !slot_excp[0];

    // bit 0 pc, 1 icache, 2 instbuffer, 3 id, 4 dispatch, 5 ex, 6 mem, 7 wb
    assign flush_o = {branch_flush_i, {4{redirect || branch_flush_i}}, {2{redirect}}, 1'b0};

    assign new_pc_o = branch_flush_i ? branch_target_i : (is_ertn ? csr_i.era : csr_i.eentry);

    assign pause_idle = commit_i[0].valid && commit_i[0].aluop == IDLE && !csr_i.is_interrupt;

    always_comb begin
        if (pause_req_i.pause_if) begin
            pause_o = 8'hff;
        end else if (pause_req_i.pause_icache) begin
            pause_o = 8'h7f;
        end else if (pause_req_i.pause_buffer) begin
            pause_o = 8'h3f;
        end else if (pause_req_i.pause_decoder) begin
            pause_o = 8'h1f;
        end else if (pause_req_i.pause_dispatch) begin
            pause_o = 8'h0f;
        end else if (pause_req_i.pause_execute) begin
            pause_o = 8'h07;
        end else if (pause_req_i.pause_mem || pause_idle) begin
            pause_o = 8'h03;
        end else begin
            pause_o = 8'h00;
        end
    end

    assign rf_we_o[0] = wb_i[0].reg_write_en && !slot_excp[0] && !pause_o[0];
    assign rf_we_o[1] = wb_i[1].reg_write_en && !any_excp && !pause_o[0];

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_rf
        assign rf_waddr_o[i] = wb_i[i].reg_write_addr;
        assign rf_wdata_o[i] = wb_i[i].reg_write_data;
    end

    always_comb begin
        excp_o.exception      = any_excp;
        excp_o.ertn           = is_ertn;
        excp_o.exception_pc   = commit_i[xslot].pc;
        excp_o.badv_valid     = any_excp && (cause == ADEF || cause == ADEM || cause == ALE);
        // fetch faults report the pc itself
        excp_o.badv           = cause == ADEF ? commit_i[xslot].pc : commit_i[xslot].mem_addr;
        excp_o.ecode          = ecode;
        excp_o.esubcode       = esubcode;
        excp_o.csr_write_en   = wb_i[0].csr_write_en && !slot_excp[0] && !pause_o[0];
        excp_o.csr_write_addr = wb_i[0].csr_write_addr;
        excp_o.csr_write_data = wb_i[0].csr_write_data;
    end
endmodule

`default_nettype wire

/* csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_commit_defines.svh"

module csr_file
    import la_commit_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  excp_event_t excp_i,
    input  logic [7:0]  hw_int_i,
    input  apb_req_t    apb_i,
    output apb_rsp_t    apb_o,
    output csr_state_t  csr_o
);
    crmd_u                          crmd;
    logic [2:0]                     prmd;
    logic [9:0]                     ecfg_lie;
    logic [1:0]                     estat_sw;
    logic [5:0]                     estat_ecode;
    logic [8:0]                     estat_esub;
    logic [31:0]                    era;
    logic [31:0]                    badv;
    logic [31:0]                    eentry;
    logic [9:0]                     estat_is;
    logic                           commit_busy;
    logic                           apb_access;
    logic                           apb_ready;
    logic                           addr_hit;
    logic [31:0]                    rdata;
    logic                           wr_en;
    logic [`CSR_ADDR_WIDTH-1:0]     wr_addr;
    logic [31:0]                    wr_data;

    assign estat_is = {hw_int_i, estat_sw};

    // commit path owns the write port whenever it has something to do
    assign commit_busy = excp_i.exception || excp_i.ertn || excp_i.csr_write_en;
    assign apb_access  = apb_i.psel && apb_i.penable;
    assign apb_ready   = apb_access && !commit_busy;

    assign wr_en   = excp_i.csr_write_en || (apb_ready && apb_i.pwrite && addr_hit);
    assign wr_addr = excp_i.csr_write_en ? excp_i.csr_write_addr : apb_i.paddr;
    assign wr_data = excp_i.csr_write_en ? excp_i.csr_write_data : apb_i.pwdata;

    always_comb begin
        addr_hit = 1'b1;
        case (apb_i.paddr)
            `CSR_CRMD:   rdata = crmd.raw;
            `CSR_PRMD:   rdata = {29'b0, prmd};
            `CSR_ECFG:   rdata = {22'b0, ecfg_lie};
            `CSR_ESTAT:  rdata = {1'b0, estat_esub, estat_ecode, 6'b0, estat_is};
            `CSR_ERA:    rdata = era;
            `CSR_BADV:   rdata = badv;
            `CSR_EENTRY: rdata = eentry;
            default: begin
                rdata    = 32'b0;
                addr_hit = 1'b0;
            end
        endcase
    end

    assign apb_o = '{pready: apb_ready, prdata: rdata, pslverr: apb_ready && !addr_hit};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crmd.raw    <= 32'b0;
            prmd        <= 3'b0;
            ecfg_lie    <= 10'b0;
            estat_sw    <= 2'b0;
            estat_ecode <= 6'b0;
            estat_esub  <= 9'b0;
            era         <= 32'b0;
            badv        <= 32'b0;
            eentry      <= 32'b0;
        end else if (excp_i.exception) begin
            prmd          <= {crmd.f.ie, crmd.f.plv};
            crmd.f.plv    <= 2'b00;
            crmd.f.ie     <= 1'b0;
            era           <= excp_i.exception_pc;
            estat_ecode   <= excp_i.ecode;
            estat_esub    <= excp_i.esubcode;
            if (excp_i.badv_valid) begin
                badv <= excp_i.badv;
            end
        end else if (excp_i.ertn) begin
            crmd.f.plv <= prmd[1:0];
            crmd.f.ie  <= prmd[2];
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_CRMD:   crmd.raw <= {28'b0, wr_data[3:0]};
                `CSR_PRMD:   prmd     <= wr_data[2:0];
                `CSR_ECFG:   ecfg_lie <= wr_data[9:0];
                // only the software interrupt bits are writable
                `CSR_ESTAT:  estat_sw <= wr_data[1:0];
                `CSR_ERA:    era      <= wr_data;
                `CSR_BADV:   badv     <= wr_data;
                `CSR_EENTRY: eentry   <= wr_data;
                default: ;
            endcase
        end
    end

    assign csr_o = '{
        crmd:         crmd,
        era:          era,
        eentry:       eentry,
        is_interrupt: crmd.f.ie && (ecfg_lie & estat_is) != 10'b0
    };

    a_excp_ertn_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(excp_i.exception && excp_i.ertn))
        else $error("exception and ertn in the same cycle");

    // a stalled access keeps its request until pready
    a_apb_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        apb_access && !apb_ready |=>
            apb_access && $stable(apb_i.paddr) && $stable(apb_i.pwrite))
        else $error("APB request dropped or changed while stalled");
endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_commit_defines.svh"

module reg_file (
    input  logic                                            clk,
    input  logic                                            arst_n_i,
    input  logic [`ISSUE_WIDTH-1:0]                         we_i,
    input  logic [`ISSUE_WIDTH-1:0][`REG_ADDR_WIDTH-1:0]    waddr_i,
    input  logic [`ISSUE_WIDTH-1:0][31:0]                   wdata_i,
    input  logic [`ISSUE_WIDTH-1:0][`REG_ADDR_WIDTH-1:0]    raddr_i,
    output logic [`ISSUE_WIDTH-1:0][31:0]                   rdata_o
);
    logic [31:0] regs [32];

    // slot 1 is applied last so it wins on a shared address
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= 32'b0;
            end
        end else begin
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                if (we_i[s] && waddr_i[s] != '0) begin
                    regs[waddr_i[s]] <= wdata_i[s];
                end
            end
        end
    end

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_rd
        assign rdata_o[i] = raddr_i[i] == '0 ? 32'b0 : regs[raddr_i[i]];
    end
endmodule

`default_nettype wire

/* la_commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_commit_defines.svh"

module la_commit_top
    import la_commit_pkg::*;
(
    input  logic                                            clk,
    input  logic                                            arst_n_i,
    input  pause_t                                          pause_req_i,
    input  logic                                            branch_flush_i,
    input  logic [31:0]                                     branch_target_i,
    input  mem_wb_t                                         wb_i [`ISSUE_WIDTH],
    input  commit_ctrl_t                                    commit_i [`ISSUE_WIDTH],
    input  logic [7:0]                                      hw_int_i,
    input  apb_req_t                                        apb_i,
    output apb_rsp_t                                        apb_o,
    input  logic [`ISSUE_WIDTH-1:0][`REG_ADDR_WIDTH-1:0]    rf_raddr_i,
    output logic [`ISSUE_WIDTH-1:0][31:0]                   rf_rdata_o,
    output logic [`PIPE_WIDTH-1:0]                          flush_o,
    output logic [`PIPE_WIDTH-1:0]                          pause_o,
    output logic [31:0]                                     new_pc_o,
    output logic                                            is_interrupt_o
);
    excp_event_t                                    excp;
    csr_state_t                                     csr_state;
    logic [`ISSUE_WIDTH-1:0]                        rf_we;
    logic [`ISSUE_WIDTH-1:0][`REG_ADDR_WIDTH-1:0]   rf_waddr;
    logic [`ISSUE_WIDTH-1:0][31:0]                  rf_wdata;

    assign is_interrupt_o = csr_state.is_interrupt;

    commit_ctrl u_commit (
        .pause_req_i     (pause_req_i),
        .branch_flush_i  (branch_flush_i),
        .branch_target_i (branch_target_i),
        .wb_i            (wb_i),
        .commit_i        (commit_i),
        .csr_i           (csr_state),
        .excp_o          (excp),
        .flush_o         (flush_o),
        .pause_o         (pause_o),
        .new_pc_o        (new_pc_o),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata)
    );

    csr_file u_csr (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .excp_i   (excp),
        .hw_int_i (hw_int_i),
        .apb_i    (apb_i),
        .apb_o    (apb_o),
        .csr_o    (csr_state)
    );

    reg_file u_rf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr_i  (rf_raddr_i),
        .rdata_o  (rf_rdata_o)
    );
endmodule

`default_nettype wire

/* tb_la_commit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "la_commit_defines.svh"

module tb_la_commit
    import la_commit_pkg::*;
();
    localparam int TIMEOUT = 50;

    logic                                           clk;
    logic                                           arst_n;
    pause_t                                         pause_req;
    logic                                           branch_flush;
    logic [31:0]                                    branch_target;
    mem_wb_t                                        wb [`ISSUE_WIDTH];
    commit_ctrl_t                                   cm [`ISSUE_WIDTH];
    logic [7:0]                                     hw_int;
    apb_req_t                                       apb;
    apb_rsp_t                                       apb_o;
    logic [`ISSUE_WIDTH-1:0][`REG_ADDR_WIDTH-1:0]   raddr;
    logic [`ISSUE_WIDTH-1:0][31:0]                  rdata;
    logic [`PIPE_WIDTH-1:0]                         flush_o;
    logic [`PIPE_WIDTH-1:0]                         pause_o;
    logic [31:0]                                    new_pc_o;
    logic                                           is_interrupt_o;

    int          errors;
    int          checks;
    int          tests;
    int          err_mark;
    logic [31:0] rng;
    logic [31:0] rd;
    logic        err;
    logic [31:0] d0;
    logic [31:0] d1;

    la_commit_top dut0 (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .pause_req_i     (pause_req),
        .branch_flush_i  (branch_flush),
        .branch_target_i (branch_target),
        .wb_i            (wb),
        .commit_i        (cm),
        .hw_int_i        (hw_int),
        .apb_i           (apb),
        .apb_o           (apb_o),
        .rf_raddr_i      (raddr),
        .rf_rdata_o      (rdata),
        .flush_o         (flush_o),
        .pause_o         (pause_o),
        .new_pc_o        (new_pc_o),
        .is_interrupt_o  (is_interrupt_o)
    );

    always #4 clk = ~clk;

    // pipeline invariants, checked on every edge
    a_pc_no_flush: assert property (@(posedge clk) disable iff (!arst_n) flush_o[0] == 1'b0)
        else begin
            errors++;
            $display("FAILED flush_o 0x%h has bit 0 set", $sampled(flush_o));
        end
    a_pause_shape: assert property (@(posedge clk) disable iff (!arst_n)
        pause_o inside {8'h00, 8'h03, 8'h07, 8'h0f, 8'h1f, 8'h3f, 8'h7f, 8'hff})
        else begin
            errors++;
            $display("FAILED pause_o 0x%h is not a thermometer code", $sampled(pause_o));
        end
    a_err_with_ready: assert property (@(posedge clk) disable iff (!arst_n)
        apb_o.pslverr |-> apb_o.pready)
        else begin
            errors++;
            $display("APB slave error raised outside a completing cycle");
        end
    // commit csr write owns the port, so the bus must stall
    a_backpressure: assert property (@(posedge clk) disable iff (!arst_n)
        (apb.psel && apb.penable && wb[0].csr_write_en && pause_o == 8'h00) |-> !apb_o.pready)
        else begin
            errors++;
            $display("APB access completed during a commit CSR write");
        end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
            end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, errors == err_mark ? "ok" : "errors");
        err_mark = errors;
    endtask

    task automatic clear_inputs();
        pause_req     = '0;
        branch_flush  = 1'b0;
        branch_target = 32'b0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            wb[i] = '0;
            cm[i] = '0;
        end
    endtask

    task automatic slot_write(input int slot, input logic [4:0] addr, input logic [31:0] data);
        cm[slot].valid          = 1'b1;
        wb[slot].reg_write_en   = 1'b1;
        wb[slot].reg_write_addr = addr;
        wb[slot].reg_write_data = data;
    endtask

    // access phase already driven, holds until pready
    task automatic wait_ready(output logic [31:0] data, output logic slverr);
        int n;
        n = 0;
        #1;
        while (!apb_o.pready && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!apb_o.pready) begin
            $display("APB transfer timed out waiting for pready");
            $display("Verification failed");
            $finish;
        end else begin
            data   = apb_o.prdata;
            slverr = apb_o.pslverr;
            @(negedge clk);
            apb = '0;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [13:0] addr, input logic [31:0] wdata,
                            output logic [31:0] data, output logic slverr);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = wr;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(negedge clk);
        apb.penable = 1'b1;
        wait_ready(data, slverr);
    endtask

    task automatic apb_read(input logic [13:0] addr, output logic [31:0] data);
        logic slverr;
        apb_xfer(1'b0, addr, 32'b0, data, slverr);
    endtask

    task automatic apb_write(input logic [13:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_rd;
        logic        slverr;
        apb_xfer(1'b1, addr, wdata, unused_rd, slverr);
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        hw_int   = 8'h00;
        apb      = '0;
        raddr    = '0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        err_mark = 0;
        rng      = 32'hd4dc;
        clear_inputs();
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        @(negedge clk);
        #1;
        check_eq("flush_o", 32'(flush_o), 32'h0);
        check_eq("pause_o", 32'(pause_o), 32'h0);
        check_eq("is_interrupt_o", 32'(is_interrupt_o), 32'h0);
        apb_read(`CSR_CRMD, rd);
        check_eq("crmd", rd, 32'h0);
        apb_read(`CSR_ERA, rd);
        check_eq("era", rd, 32'h0);
        apb_read(`CSR_EENTRY, rd);
        check_eq("eentry", rd, 32'h0);
        apb_xfer(1'b0, 14'h3, 32'b0, rd, err);
        check_eq("pslverr", 32'(err), 32'h1);
        finish_test("reset state");

        rng = next_rand(rng);
        d0  = rng;
        rng = next_rand(rng);
        d1  = rng;
        @(negedge clk);
        slot_write(0, 5'd5, d0);
        slot_write(1, 5'd6, d1);
        @(negedge clk);
        clear_inputs();
        raddr[0] = 5'd5;
        raddr[1] = 5'd6;
        #1;
        check_eq("rf_rdata_o[0]", rdata[0], d0);
        check_eq("rf_rdata_o[1]", rdata[1], d1);
        @(negedge clk);
        rng = next_rand(rng);
        slot_write(0, 5'd0, rng);
        @(negedge clk);
        clear_inputs();
        raddr[0] = 5'd0;
        #1;
        check_eq("rf_rdata_o[0] r0", rdata[0], 32'h0);
        @(negedge clk);
        slot_write(0, 5'd5, ~d0);
        slot_write(1, 5'd6, ~d1);
        pause_req.pause_mem = 1'b1;
        #1;
        check_eq("pause_o", 32'(pause_o), 32'h03);
        @(negedge clk);
        clear_inputs();
        raddr[0] = 5'd5;
        #1;
        check_eq("rf_rdata_o[0] paused", rdata[0], d0);
        check_eq("rf_rdata_o[1] paused", rdata[1], d1);
        for (int i = 0; i < 7; i++) begin
            @(negedge clk);
            pause_req = pause_t'(7'h40 >> i);
            #1;
            check_eq("pause_o", 32'(pause_o), 32'(8'hff >> i));
        end
        @(negedge clk);
        clear_inputs();
        finish_test("normal commit");

        apb_write(`CSR_EENTRY, 32'h1c00_0100);
        rng = next_rand(rng);
        d0  = rng;
        @(negedge clk);
        slot_write(0, 5'd7, d0);
        slot_write(1, 5'd8, ~d0);
        cm[1].pc                 = 32'h1c00_0044;
        cm[1].is_exception[3]    = 1'b1;
        cm[1].exception_cause[3] = SYS;
        #1;
        check_eq("flush_o", 32'(flush_o), 32'h7e);
        check_eq("new_pc_o", new_pc_o, 32'h1c00_0100);
        @(negedge clk);
        clear_inputs();
        raddr[0] = 5'd7;
        raddr[1] = 5'd8;
        #1;
        check_eq("rf_rdata_o[0]", rdata[0], d0);
        check_eq("rf_rdata_o[1]", rdata[1], 32'h0);
        apb_read(`CSR_ERA, rd);
        check_eq("era", rd, 32'h1c00_0044);
        apb_read(`CSR_ESTAT, rd);
        check_eq("estat.ecode", 32'(rd[21:16]), 32'hb);
        @(negedge clk);
        slot_write(0, 5'd9, d0);
        slot_write(1, 5'd10, d0);
        cm[0].mem_addr           = 32'h0000_1233;
        cm[0].is_exception[4]    = 1'b1;
        cm[0].exception_cause[4] = ALE;
        @(negedge clk);
        clear_inputs();
        raddr[0] = 5'd9;
        raddr[1] = 5'd10;
        #1;
        check_eq("rf_rdata_o[0]", rdata[0], 32'h0);
        check_eq("rf_rdata_o[1]", rdata[1], 32'h0);
        apb_read(`CSR_BADV, rd);
        check_eq("badv", rd, 32'h0000_1233);
        finish_test("exception");

        apb_write(`CSR_CRMD, 32'h4);
        @(negedge clk);
        cm[0].valid              = 1'b1;
        cm[0].pc                 = 32'h1c00_0200;
        cm[0].is_exception[3]    = 1'b1;
        cm[0].exception_cause[3] = SYS;
        @(negedge clk);
        clear_inputs();
        apb_read(`CSR_CRMD, rd);
        check_eq("crmd after entry", rd, 32'h0);
        @(negedge clk);
        cm[0].valid = 1'b1;
        cm[0].aluop = ERTN;
        #1;
        check_eq("new_pc_o", new_pc_o, 32'h1c00_0200);
        check_eq("flush_o", 32'(flush_o), 32'h7e);
        @(negedge clk);
        clear_inputs();
        apb_read(`CSR_CRMD, rd);
        check_eq("crmd after ertn", rd, 32'h4);
        @(negedge clk);
        branch_flush  = 1'b1;
        branch_target = 32'h1c00_0abc;
        #1;
        check_eq("flush_o", 32'(flush_o), 32'hf8);
        check_eq("new_pc_o", new_pc_o, 32'h1c00_0abc);
        @(negedge clk);
        clear_inputs();
        finish_test("ertn and branch");

        // hw line 0 sits at estat bit 2
        apb_write(`CSR_ECFG, 32'h4);
        @(negedge clk);
        hw_int = 8'h01;
        #1;
        check_eq("is_interrupt_o", 32'(is_interrupt_o), 32'h1);
        @(negedge clk);
        cm[0].valid = 1'b1;
        cm[0].aluop = IDLE;
        cm[0].pc    = 32'h1c00_0300;
        #1;
        check_eq("pause_o", 32'(pause_o), 32'h0);
        check_eq("flush_o", 32'(flush_o), 32'h7e);
        @(negedge clk);
        clear_inputs();
        #1;
        check_eq("is_interrupt_o", 32'(is_interrupt_o), 32'h0);
        apb_read(`CSR_ESTAT, rd);
        check_eq("estat.ecode", 32'(rd[21:16]), 32'h0);
        apb_read(`CSR_ERA, rd);
        check_eq("era", rd, 32'h1c00_0300);
        @(negedge clk);
        cm[0].valid = 1'b1;
        cm[0].aluop = IDLE;
        #1;
        check_eq("pause_o idle", 32'(pause_o), 32'h03);
        @(negedge clk);
        clear_inputs();
        hw_int = 8'h00;
        apb_write(`CSR_CRMD, 32'h3);
        @(negedge clk);
        cm[0].valid              = 1'b1;
        cm[0].is_privilege       = 1'b1;
        cm[0].is_exception[2]    = 1'b1;
        cm[0].exception_cause[2] = INE;
        @(negedge clk);
        clear_inputs();
        apb_read(`CSR_ESTAT, rd);
        check_eq("estat.ecode", 32'(rd[21:16]), 32'he);
        finish_test("interrupts");

        @(negedge clk);
        apb.psel   = 1'b1;
        apb.pwrite = 1'b1;
        apb.paddr  = `CSR_ERA;
        apb.pwdata = 32'h1c00_0aaa;
        @(negedge clk);
        apb.penable           = 1'b1;
        cm[0].valid           = 1'b1;
        wb[0].csr_write_en    = 1'b1;
        wb[0].csr_write_addr  = `CSR_ERA;
        wb[0].csr_write_data  = 32'h1c00_0ccc;
        #1;
        check_eq("pready", 32'(apb_o.pready), 32'h0);
        @(negedge clk);
        clear_inputs();
        wait_ready(rd, err);
        check_eq("pslverr", 32'(err), 32'h0);
        apb_read(`CSR_ERA, rd);
        check_eq("era", rd, 32'h1c00_0aaa);
        finish_test("apb backpressure");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* la_commit.f */
+incdir+.
la_commit_pkg.sv
excp_encoder.sv
commit_ctrl.sv
csr_file.sv
reg_file.sv
la_commit_top.sv
tb_la_commit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench under Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_la_commit \
    -f la_commit.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_la_commit > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }
cat sim.log
grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
